//--- spi_multi_ctrl.f
hdl/spi_cmd_pkg.sv
hdl/spi_master_pkg.sv
hdl/spi_cmd_dispatch.sv
hdl/spi_master.sv
hdl/spi_read_collect.sv
hdl/spi_multi_ctrl.sv
verif/tb_clk_gen.sv
verif/spi_multi_ctrl_props.sv
verif/spi_multi_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module spi_multi_ctrl_tb -f spi_multi_ctrl.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
  echo "simulation FAILED"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation PASSED"
exit 0

//--- verif/spi_multi_ctrl_tb.sv
`timescale 1ns/1ps

module spi_multi_ctrl_tb
  import spi_cmd_pkg::*;
();

  localparam int N_CHAN    = 4;
  localparam int CLK_DIV   = 2;
  localparam int TURN_GAP  = 8;
  localparam int CHAN_W    = $clog2(N_CHAN);
  localparam int N_REGS    = 2 ** ADDR_WIDTH;
  localparam int SEED      = 76205;
  localparam int N_CMDS    = 300;
  // read header plus data bits plus the start and done cycles
  localparam int MAX_FRAME   = (READ_HDR_BITS + DATA_WIDTH) * 2 * CLK_DIV + 2;
  localparam int WATCHDOG_NS = N_CMDS * (MAX_FRAME + TURN_GAP + N_CHAN) * 10 * 2;

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic [CHAN_W-1:0]     cmd_chan;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic [N_CHAN-1:0]     miso;
  logic [N_CHAN-1:0]     sclk;
  logic [N_CHAN-1:0]     cs;
  logic [N_CHAN-1:0]     mosi;
  logic                  read_vld;
  logic [CHAN_W-1:0]     read_chan;
  logic [DATA_WIDTH-1:0] read_data;

  // reference model and scoreboard
  logic [DATA_WIDTH-1:0] model [N_CHAN][N_REGS];
  logic [DATA_WIDTH-1:0] exp_q [N_CHAN][$];
  logic [CMD_WIDTH-1:0]  cur_cmd [N_CHAN];
  int                    accept_cnt [N_CHAN];
  int                    done_cnt [N_CHAN];
  int                    rd_idx [N_CHAN] = '{default: 0};
  int                    overlap_cnt;

  tb_clk_gen #(
    .PERIOD_NS  (10),
    .RST_CYCLES (5)
  ) u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  spi_multi_ctrl #(
    .N_CHAN   (N_CHAN),
    .CLK_DIV  (CLK_DIV),
    .TURN_GAP (TURN_GAP)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_chan  (cmd_chan),
    .cmd_vld   (cmd_vld),
    .miso      (miso),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .read_vld  (read_vld),
    .read_chan (read_chan),
    .read_data (read_data)
  );

  task automatic halt_with_error(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string test, input int expected, input int actual);
    halt_with_error($sformatf("Fail %s: expected 0x%0h, actual 0x%0h", test, expected, actual));
  endtask

  task automatic check_reset_state();
    assert (cs == '1) else report_mismatch("reset cs", (1 << N_CHAN) - 1, int'(cs));
    assert (sclk == '0) else report_mismatch("reset sclk", 0, int'(sclk));
    assert (mosi == '0) else report_mismatch("reset mosi", 0, int'(mosi));
    assert (read_vld == 1'b0) else report_mismatch("reset read_vld", 0, int'(read_vld));
    for (int c = 0; c < N_CHAN; c++)
    begin
      cmd_chan = CHAN_W'(c);
      #1;
      assert (cmd_rdy) else report_mismatch($sformatf("reset cmd_rdy ch%0d", c), 1, 0);
    end
    cmd_chan = '0;
  endtask

  function automatic int busy_others(input int chan);
    int n = 0;
    for (int c = 0; c < N_CHAN; c++)
    begin
      if (c != chan && accept_cnt[c] != done_cnt[c])
        n++;
    end
    return n;
  endfunction

  function automatic bit channels_drained();
    for (int c = 0; c < N_CHAN; c++)
    begin
      if (accept_cnt[c] != done_cnt[c] || rd_idx[c] != exp_q[c].size())
        return 1'b0;
    end
    return 1'b1;
  endfunction

  initial
  begin : stimulus
    int                    chan;
    int                    gap;
    spi_op_e               op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    void'($urandom(SEED));
    cmd_in      = '0;
    cmd_chan    = '0;
    cmd_vld     = 1'b0;
    overlap_cnt = 0;
    for (int c = 0; c < N_CHAN; c++)
    begin
      accept_cnt[c] = 0;
      cur_cmd[c]    = '0;
      for (int r = 0; r < N_REGS; r++)
        model[c][r] = '0;
    end
    @(posedge rst_n);
    @(negedge clk);
    check_reset_state();
    @(negedge clk);
    for (int n = 0; n < N_CMDS; n++)
    begin
      chan     = int'($urandom_range(N_CHAN - 1));
      op       = spi_op_e'(1'($urandom_range(1)));
      addr     = ADDR_WIDTH'($urandom_range(N_REGS - 1));
      data     = DATA_WIDTH'($urandom_range(255));
      cmd_chan = CHAN_W'(chan);
      cmd_in   = {op, addr, data};
      cmd_vld  = 1'b1;
      #1;
      // hold until the addressed channel is free
      while (!cmd_rdy)
      begin
        @(negedge clk);
        #1;
      end
      assert (accept_cnt[chan] == done_cnt[chan])
        else halt_with_error($sformatf("cmd_rdy high while channel %0d still busy", chan));
      overlap_cnt += busy_others(chan);
      accept_cnt[chan]++;
      cur_cmd[chan] = cmd_in;
      if (op == OP_WRITE)
        model[chan][addr] = data;
      else
        exp_q[chan].push_back(model[chan][addr]);
      @(negedge clk);
      cmd_vld = 1'b0;
      gap = int'($urandom_range(3));
      repeat (gap) @(negedge clk);
    end
    while (!channels_drained())
      @(negedge clk);
    assert (overlap_cnt > 0)
      else halt_with_error("no command was accepted while another channel was busy");
    $display("No errors");
    $finish;
  end

  always @(negedge clk)
  begin : read_check
    int                    ch;
    logic [DATA_WIDTH-1:0] exp_v;
    if (rst_n && read_vld)
    begin
      ch = int'(read_chan);
      assert (rd_idx[ch] < exp_q[ch].size())
        else halt_with_error($sformatf("read result on channel %0d with no read outstanding", ch));
      exp_v = exp_q[ch][rd_idx[ch]];
      assert (read_data == exp_v)
        else report_mismatch($sformatf("read_data ch%0d", ch), int'(exp_v), int'(read_data));
      rd_idx[ch]++;
    end
  end

  // spi device per channel sampled mid-cycle
  for (genvar g = 0; g < N_CHAN; g++)
  begin : g_dev
    logic [DATA_WIDTH-1:0] regs [N_REGS] = '{default: '0};
    logic [CMD_WIDTH-1:0]  word = '0;
    logic [DATA_WIDTH-1:0] tx = '0;
    logic                  so = 1'b0;
    logic                  cs_q = 1'b1;
    logic                  sclk_q = 1'b0;
    logic                  rd_pend = 1'b0;
    int                    nbits = 0;
    int                    dcnt = 0;

    assign miso[g]     = so;
    assign done_cnt[g] = dcnt;

    always @(negedge clk)
    begin
      if (!cs[g])
      begin
        if (cs_q)
        begin
          nbits = 0;
          word  = '0;
        end
        if (sclk[g] && !sclk_q)
        begin
          word  = {word[CMD_WIDTH-2:0], mosi[g]};
          nbits = nbits + 1;
        end
        // next data bit after each falling sclk
        if (!sclk[g] && sclk_q && rd_pend)
        begin
          tx = {tx[DATA_WIDTH-2:0], 1'b0};
          so = tx[DATA_WIDTH-1];
        end
      end
      else if (!cs_q)
      begin
        if (rd_pend)
        begin
          assert (nbits == DATA_WIDTH)
            else report_mismatch($sformatf("read data edges ch%0d", g), DATA_WIDTH, nbits);
          rd_pend = 1'b0;
          so      = 1'b0;
          dcnt    = dcnt + 1;
        end
        else if (cur_cmd[g][OP_BIT])
        begin
          assert (nbits == CMD_WIDTH)
            else report_mismatch($sformatf("write edges ch%0d", g), CMD_WIDTH, nbits);
          assert (word == cur_cmd[g])
            else report_mismatch($sformatf("write mosi ch%0d", g), int'(cur_cmd[g]), int'(word));
          regs[word[ADDR_LSB +: ADDR_WIDTH]] = word[DATA_WIDTH-1:0];
          dcnt = dcnt + 1;
        end
        else
        begin
          assert (nbits == READ_HDR_BITS)
            else report_mismatch($sformatf("read header edges ch%0d", g), READ_HDR_BITS, nbits);
          assert (word[READ_HDR_BITS-1:0] == cur_cmd[g][OP_BIT -: READ_HDR_BITS])
            else report_mismatch($sformatf("read header mosi ch%0d", g),
                                 int'(cur_cmd[g][OP_BIT -: READ_HDR_BITS]),
                                 int'(word[READ_HDR_BITS-1:0]));
          // msb waits on miso through the turnaround
          tx      = regs[word[ADDR_WIDTH-1:0]];
          so      = tx[DATA_WIDTH-1];
          rd_pend = 1'b1;
        end
      end
      cs_q   = cs[g];
      sclk_q = sclk[g];
    end
  end

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    halt_with_error($sformatf("timeout: run did not finish within %0d ns", WATCHDOG_NS));
  end

endmodule

//--- verif/spi_multi_ctrl_props.sv
`timescale 1ns/1ps

module spi_multi_ctrl_props
  import spi_master_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input spi_state_e state,
  input logic       start,
  input logic       idle,
  input logic       cs,
  input logic       sclk,
  input logic       rd_vld
);

  a_idle_cs: assert property (@(posedge clk) disable iff (!rst_n) (state == IDLE) |-> cs)
    else $error("cs low while master idle");

  a_sclk_low: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
    else $error("sclk high while cs deasserted");

  a_rd_pulse: assert property (@(posedge clk) disable iff (!rst_n) rd_vld |=> !rd_vld)
    else $error("rd_vld held for two cycles");

  a_start_busy: assert property (@(posedge clk) disable iff (!rst_n) start |=> !idle)
    else $error("idle still high the cycle after start");

endmodule

bind spi_master spi_multi_ctrl_props u_props (
  .clk    (clk),
  .rst_n  (rst_n),
  .state  (state),
  .start  (start),
  .idle   (idle),
  .cs     (cs),
  .sclk   (sclk),
  .rd_vld (rd_vld)
);

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release away from the rising edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- hdl/spi_multi_ctrl.sv
`timescale 1ns/1ps

module spi_multi_ctrl
  import spi_cmd_pkg::*;
#(
  parameter int N_CHAN   = 4,
  parameter int CLK_DIV  = 5,
  parameter int TURN_GAP = 16
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [CMD_WIDTH-1:0]                          cmd_in,
  input  logic [((N_CHAN > 1) ? $clog2(N_CHAN) : 1)-1:0] cmd_chan,
  input  logic                                          cmd_vld,
  input  logic [N_CHAN-1:0]                             miso,
  output logic                                          cmd_rdy,
  output logic [N_CHAN-1:0]                             sclk,
  output logic [N_CHAN-1:0]                             cs,
  output logic [N_CHAN-1:0]                             mosi,
  output logic                                          read_vld,
  output logic [((N_CHAN > 1) ? $clog2(N_CHAN) : 1)-1:0] read_chan,
  output logic [DATA_WIDTH-1:0]                         read_data
);

  logic [N_CHAN-1:0]                 start;
  logic [N_CHAN-1:0]                 idle;
  logic [N_CHAN-1:0][CMD_WIDTH-1:0]  cmd;
  logic [N_CHAN-1:0]                 rd_vld;
  logic [N_CHAN-1:0][DATA_WIDTH-1:0] rd_data;

  spi_cmd_dispatch #(
    .N_CHAN (N_CHAN)
  ) u_dispatch (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_chan (cmd_chan),
    .cmd_vld  (cmd_vld),
    .idle     (idle),
    .cmd_rdy  (cmd_rdy),
    .start    (start),
    .cmd      (cmd)
  );

  // one independent master per channel
  for (genvar i = 0; i < N_CHAN; i++)
  begin : g_chan
    spi_master #(
      .CLK_DIV  (CLK_DIV),
      .TURN_GAP (TURN_GAP)
    ) u_master (
      .clk     (clk),
      .rst_n   (rst_n),
      .start   (start[i]),
      .cmd     (cmd[i]),
      .miso    (miso[i]),
      .idle    (idle[i]),
      .sclk    (sclk[i]),
      .cs      (cs[i]),
      .mosi    (mosi[i]),
      .rd_vld  (rd_vld[i]),
      .rd_data (rd_data[i])
    );
  end

  spi_read_collect #(
    .N_CHAN (N_CHAN)
  ) u_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_vld    (rd_vld),
    .rd_data   (rd_data),
    .read_vld  (read_vld),
    .read_chan (read_chan),
    .read_data (read_data)
  );

endmodule

//--- hdl/spi_read_collect.sv
`timescale 1ns/1ps

module spi_read_collect
  import spi_cmd_pkg::*;
#(
  parameter int N_CHAN = 4
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [N_CHAN-1:0]                             rd_vld,
  input  logic [N_CHAN-1:0][DATA_WIDTH-1:0]             rd_data,
  output logic                                          read_vld,
  output logic [((N_CHAN > 1) ? $clog2(N_CHAN) : 1)-1:0] read_chan,
  output logic [DATA_WIDTH-1:0]                         read_data
);

  localparam int CHAN_W = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;
  localparam logic [CHAN_W-1:0] PTR_LAST = CHAN_W'(N_CHAN - 1);

  logic [N_CHAN-1:0]                 pend;
  logic [N_CHAN-1:0][DATA_WIDTH-1:0] data_q;
  logic [CHAN_W-1:0]                 ptr;
  logic                              issue;

  // pointer visits every channel in turn
  assign issue = pend[ptr];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pend     <= '0;
      ptr      <= '0;
      read_vld <= 1'b0;
    end
    else
    begin
      ptr      <= (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
      read_vld <= issue;
      // a new result wins over the clear
      pend <= (issue ? (pend & ~(N_CHAN'(1) << ptr)) : pend) | rd_vld;
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < N_CHAN; i++)
    begin
      if (rd_vld[i])
        data_q[i] <= rd_data[i];
    end
    if (issue)
    begin
      read_chan <= ptr;
      read_data <= data_q[ptr];
    end
  end

endmodule

//--- hdl/spi_master.sv
`timescale 1ns/1ps

module spi_master
  import spi_cmd_pkg::*;
  import spi_master_pkg::*;
#(
  parameter int CLK_DIV  = 5,
  parameter int TURN_GAP = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic [CMD_WIDTH-1:0]  cmd,
  input  logic                  miso,
  output logic                  idle,
  output logic                  sclk,
  output logic                  cs,
  output logic                  mosi,
  output logic                  rd_vld,
  output logic [DATA_WIDTH-1:0] rd_data
);

  localparam int DIV_W = $clog2(2 * CLK_DIV);
  localparam int GAP_W = $clog2(TURN_GAP + 1);
  localparam int BIT_W = $clog2(CMD_WIDTH);

  localparam logic [DIV_W-1:0] DIV_MID  = DIV_W'(CLK_DIV - 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(2 * CLK_DIV - 1);
  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(TURN_GAP - 1);

  spi_state_e            state;
  spi_op_e               op;
  logic [DIV_W-1:0]      div_cnt;
  logic [BIT_W-1:0]      bit_cnt;
  logic [GAP_W-1:0]      gap_cnt;
  logic [CMD_WIDTH-1:0]  tx_sr;
  logic [DATA_WIDTH-1:0] rx_sr;
  logic                  shifting;
  logic                  bit_end;
  logic                  last_bit;

  assign op       = spi_op_e'(cmd[OP_BIT]);
  assign idle     = (state == IDLE);
  assign shifting = (state == W_SHIFT) || (state == R_HDR) || (state == R_DATA);
  assign bit_end  = (div_cnt == DIV_LAST);
  assign rd_data  = rx_sr;

  // frame length depends on which frame is running
  always_comb
  begin
    case (state)
      W_SHIFT: last_bit = (bit_cnt == BIT_W'(CMD_WIDTH - 1));
      R_HDR:   last_bit = (bit_cnt == BIT_W'(READ_HDR_BITS - 1));
      default: last_bit = (bit_cnt == BIT_W'(DATA_WIDTH - 1));
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      gap_cnt <= '0;
      sclk    <= 1'b0;
      cs      <= 1'b1;
      mosi    <= 1'b0;
      rd_vld  <= 1'b0;
    end
    else
    begin
      rd_vld <= 1'b0;
      case (state)
        IDLE:
        begin
          if (start)
          begin
            cs      <= 1'b0;
            mosi    <= cmd[OP_BIT];
            div_cnt <= '0;
            bit_cnt <= '0;
            state   <= (op == OP_WRITE) ? W_SHIFT : R_HDR;
          end
        end
        W_SHIFT, R_HDR, R_DATA:
        begin
          // sclk high for the second half of each bit
          if (div_cnt == DIV_MID)
          begin
            sclk <= 1'b1;
          end
          if (bit_end)
          begin
            sclk    <= 1'b0;
            div_cnt <= '0;
            if (last_bit)
            begin
              cs      <= 1'b1;
              mosi    <= 1'b0;
              bit_cnt <= '0;
              if (state == R_HDR)
              begin
                gap_cnt <= '0;
                state   <= R_GAP;
              end
              else
              begin
                rd_vld <= (state == R_DATA);
                state  <= DONE;
              end
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              mosi    <= tx_sr[CMD_WIDTH-1];
            end
          end
          else
          begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        R_GAP:
        begin
          if (gap_cnt == GAP_LAST)
          begin
            cs    <= 1'b0;
            state <= R_DATA;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        DONE:
        begin
          state <= IDLE;
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // read loads only the header, so mosi stays low in the data frame
  always_ff @(posedge clk)
  begin
    if (idle && start)
    begin
      if (op == OP_WRITE)
        tx_sr <= {cmd[CMD_WIDTH-2:0], 1'b0};
      else
        tx_sr <= {cmd[CMD_WIDTH-2:ADDR_LSB], {(ADDR_LSB + 1){1'b0}}};
    end
    else if (shifting && bit_end)
    begin
      tx_sr <= {tx_sr[CMD_WIDTH-2:0], 1'b0};
    end
    // sample miso on the sclk rising edge
    if (state == R_DATA && div_cnt == DIV_MID)
    begin
      rx_sr <= {rx_sr[DATA_WIDTH-2:0], miso};
    end
  end

endmodule

//--- hdl/spi_cmd_dispatch.sv
`timescale 1ns/1ps

module spi_cmd_dispatch
  import spi_cmd_pkg::*;
#(
  parameter int N_CHAN = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [CMD_WIDTH-1:0]               cmd_in,
  input  logic [((N_CHAN > 1) ? $clog2(N_CHAN) : 1)-1:0] cmd_chan,
  input  logic                               cmd_vld,
  input  logic [N_CHAN-1:0]                  idle,
  output logic                               cmd_rdy,
  output logic [N_CHAN-1:0]                  start,
  output logic [N_CHAN-1:0][CMD_WIDTH-1:0]   cmd
);

  localparam int CHAN_W = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

  logic [N_CHAN-1:0] ready;
  logic              accept;

  // master idle drops one cycle after start, so mask the start cycle too
  assign ready   = idle & ~start;
  assign cmd_rdy = (int'(cmd_chan) < N_CHAN) && ready[cmd_chan];
  assign accept  = cmd_vld && cmd_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      start <= '0;
    end
    else
    begin
      start <= '0;
      if (accept)
      begin
        start[cmd_chan] <= 1'b1;
      end
    end
  end

  // held until the channel is idle again
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd[cmd_chan] <= cmd_in;
    end
  end

endmodule

//--- hdl/spi_master_pkg.sv
package spi_master_pkg;

  // frame sequencing of one channel
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    W_SHIFT = 3'd1,
    R_HDR   = 3'd2,
    R_GAP   = 3'd3,
    R_DATA  = 3'd4,
    DONE    = 3'd5
  } spi_state_e;

endpackage

//--- hdl/spi_cmd_pkg.sv
package spi_cmd_pkg;

  // 12-bit command word of op, 3-bit register address and 8-bit data
  localparam int CMD_WIDTH  = 12;
  localparam int ADDR_WIDTH = 3;
  localparam int DATA_WIDTH = 8;

  // field positions
  localparam int OP_BIT   = CMD_WIDTH - 1;
  localparam int ADDR_LSB = DATA_WIDTH;

  // op plus address, sent ahead of a read
  localparam int READ_HDR_BITS = 1 + ADDR_WIDTH;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

endpackage
